// ==== arcade_io.f ====
+incdir+.
arcade_io_pkg.sv
clock_enable_gen.sv
key_event_decoder.sv
player_input_mapper.sv
control_merger.sv
audio_dac.sv
arcade_io_top.sv
arcade_io_tb.sv

// ==== arcade_io_config.svh ====
//==========================================================================
// Build-time parameters of the arcade control and timing front end
//   NUM_PLAYERS  number of joystick mapping channels
//   AUDIO_W      width of the game core audio sample
//   CE_SLOW_DIV  clk_sys cycles per pulse of the slow CPU enable
//==========================================================================

`ifndef ARCADE_IO_CONFIG_SVH
`define ARCADE_IO_CONFIG_SVH

// Joystick channels, one mapper each
`define NUM_PLAYERS 2

// Sample width from the sound board
`define AUDIO_W 10

// 25 MHz / 14 gives roughly 1.79 MHz
`define CE_SLOW_DIV 14

`endif

// ==== arcade_io_pkg.sv ====
//==========================================================================
// Shared types of the arcade front end
//   Vector typedefs for scan codes, controls, keys, buttons and audio
//   Bit positions inside the control and system key vectors
//   State encoding of the keyboard decoder FSM
//==========================================================================

`include "arcade_io_config.svh"

package arcade_io_pkg;

	localparam int JOY_W = 8;

	// Joystick order with bits 6 and 7 held zero
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	localparam int SYS_COIN   = 0;
	localparam int SYS_START1 = 1;
	localparam int SYS_START2 = 2;

	typedef logic [7:0]            key_code_t;
	typedef logic [JOY_W-1:0]      joy_t;
	typedef logic [2:0]            sys_keys_t;
	typedef logic [7:0]            buttons_t;   // Active low in core order
	typedef logic [`AUDIO_W-1:0]   audio_t;

	typedef enum logic [1:0] {
		KBD_IDLE,
		KBD_BREAK,   // F0 seen
		KBD_EXT      // E0 seen
	} kbd_state_t;

endpackage

// ==== arcade_io_tb.sv ====
//==========================================================================
// Testbench for the arcade front end top level
//   LFSR stimulus, reference model of keys, rotation and button word
//   Comparing process for delayed button checks and one check task
//   Clock enable spacing, audio density and a cycle limit
//==========================================================================

`timescale 1ns/1ps

`include "arcade_io_config.svh"

module arcade_io_tb import arcade_io_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int N_SEQ        = 60;    // Key sequences of at most 8 cycles each
	localparam int N_JOY        = 40;    // Joystick steps of 3 cycles per rotate setting
	localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + N_SEQ * 8 + 2 * N_JOY * 3 + 56 + 1024);

	logic                          clk_sys;
	logic                          rst;
	key_code_t                     key_data;
	logic                          key_valid;
	logic [`NUM_PLAYERS*8-1:0]     joy_flat;
	logic                          rotate;
	audio_t                        audio;
	logic                          key_ready;
	buttons_t                      button_n;
	logic                          audio_out;
	logic                          ce_12, ce_6p, ce_6n, ce_1p79;

	int          cycle, errors, checks, audio_ones;
	int          armed_cnt, done_cnt, due;
	buttons_t    exp_word;
	string       exp_name;
	logic [31:0] lfsr = 32'h3e00;
	logic [10:0] m_keys;              // {sys keys, joystick order}
	logic        m_brk;
	logic [3:0]  ce;
	int          last_pulse [4];
	int          pulses [4];
	int          period [4] = '{2, 4, 4, 14};
	key_code_t   key_codes [12] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h29, 8'h11,
	                                8'h76, 8'h05, 8'h06, 8'h1C, 8'h5A, 8'h12};

	arcade_io_top u_arcade_io_top (
		.clk_sys (clk_sys), .rst (rst), .key_data (key_data), .key_valid (key_valid),
		.joy_flat (joy_flat), .rotate (rotate), .audio (audio), .key_ready (key_ready),
		.button_n (button_n), .audio_out (audio_out), .ce_12 (ce_12), .ce_6p (ce_6p),
		.ce_6n (ce_6n), .ce_1p79 (ce_1p79)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Random source and reference model
	// ======================================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [10:0] next_keys(input logic [10:0] keys, input key_code_t code,
	                                          input logic pressed);
		case (code)
			8'h75: keys[3]  = pressed;
			8'h72: keys[2]  = pressed;
			8'h6B: keys[1]  = pressed;
			8'h74: keys[0]  = pressed;
			8'h29: keys[4]  = pressed;
			8'h11: keys[5]  = pressed;
			8'h76: keys[8]  = pressed;   // Coin
			8'h05: keys[9]  = pressed;
			8'h06: keys[10] = pressed;
			default: ;
		endcase
		return keys;
	endfunction

	// Quarter turn where up takes left and so on
	function automatic joy_t turn_joy(input joy_t j, input logic rot);
		if (rot)
			return {2'b00, j[5], j[4], j[1], j[0], j[2], j[3]};
		return {2'b00, j[5:0]};
	endfunction

	function automatic buttons_t button_word(input logic [`NUM_PLAYERS*8-1:0] joys,
	                                         input logic [10:0] keys, input logic rot);
		joy_t     any;
		buttons_t word;
		any = '0;
		for (int p = 0; p < `NUM_PLAYERS; p++)
			any = any | turn_joy(joys[p*8 +: 8] | keys[7:0], rot);
		word = {keys[10], any[4], keys[8], keys[9], any[0], any[1], any[2], any[3]};
		return ~word;
	endfunction

	// ======================================================================
	// Checking
	// ======================================================================
	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic arm_check(input string name, input buttons_t expected, input int latency);
		exp_name = name;
		exp_word = expected;
		due      = cycle + latency;
		armed_cnt++;
	endtask

	always @(negedge clk_sys) begin
		if (armed_cnt != done_cnt && cycle == due) begin
			check_value(exp_name, 32'(exp_word), 32'(button_n));
			done_cnt++;
		end
	end

	always @(posedge clk_sys) begin
		if (rst)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	always @(negedge clk_sys)
		if (!rst && cycle >= 1 && cycle <= 1024 && audio_out)
			audio_ones++;   // Window of 1024 samples after reset

	always @(posedge clk_sys) begin
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle);
			$display("Some tests failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic send_byte(input key_code_t b);
		@(negedge clk_sys);
		key_data  = b;
		key_valid = 1'b1;
		if (b == 8'hE0)
			m_brk = 1'b0;
		else if (b == 8'hF0)
			m_brk = 1'b1;
		else begin
			m_keys = next_keys(m_keys, b, ~m_brk);
			m_brk  = 1'b0;
			arm_check($sformatf("key %02h", b), button_word(joy_flat, m_keys, rotate), 3);
		end
		@(negedge clk_sys);
		key_valid = 1'b0;
		if (b != 8'hE0 && b != 8'hF0)
			repeat (2) @(negedge clk_sys);   // Wait out the check
	endtask

	task automatic drive_joy(input logic rot);
		@(negedge clk_sys);
		for (int p = 0; p < `NUM_PLAYERS; p++)
			joy_flat[p*8 +: 8] = {2'b00, 6'(rand_bits(6))};
		rotate = rot;
		arm_check($sformatf("joy rotate %0d", rot), button_word(joy_flat, m_keys, rot), 2);
		repeat (2) @(negedge clk_sys);
	endtask

	initial begin
		rst = 1'b1;
		key_data = '0;
		key_valid = 1'b0;
		joy_flat = '0;
		rotate = 1'b0;
		audio = 10'd300;   // Constant from reset on
		m_keys = '0;
		m_brk = 1'b0;
		for (int k = 0; k < 4; k++) begin
			last_pulse[k] = -1;
			pulses[k] = 0;
		end
		repeat (RESET_CYCLES) @(negedge clk_sys);

		// Reset state
		check_value("reset button_n", 32'hFF, 32'(button_n));
		check_value("reset audio_out", 0, 32'(audio_out));
		check_value("reset enables", 0, 32'({ce_12, ce_6p, ce_6n, ce_1p79}));
		check_value("reset key_ready", 0, 32'(key_ready));
		rst = 1'b0;
		@(negedge clk_sys);
		check_value("key_ready", 1, 32'(key_ready));

		// Make and break sequences with unmapped codes mixed in
		for (int s = 0; s < N_SEQ; s++) begin
			if (rand_bits(2) == 0)
				send_byte(8'hE0);
			if (rand_bits(1) == 1)
				send_byte(8'hF0);
			send_byte(key_codes[int'(rand_bits(4)) % 12]);
		end

		for (int i = 0; i < N_JOY; i++)
			drive_joy(1'b0);
		send_byte(8'h75);   // Hold up and fire1 under rotation
		send_byte(8'h29);
		for (int i = 0; i < N_JOY; i++)
			drive_joy(1'b1);

		// Enable spacing
		for (int i = 0; i < 56; i++) begin
			@(negedge clk_sys);
			ce = {ce_1p79, ce_6n, ce_6p, ce_12};
			check_value("ce_6 phase", 0, 32'((ce_6p & ce_6n) | ((ce_6p | ce_6n) & ~ce_12)));
			for (int k = 0; k < 4; k++) begin
				if (ce[k]) begin
					if (last_pulse[k] >= 0)
						check_value($sformatf("ce %0d period", k), period[k], i - last_pulse[k]);
					last_pulse[k] = i;
					pulses[k]++;
				end
			end
		end
		for (int k = 0; k < 4; k++)
			check_value($sformatf("ce %0d count", k), 56 / period[k], pulses[k]);

		while (cycle <= 1024)
			@(negedge clk_sys);
		check_value("audio ones", 300, audio_ones);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== arcade_io_top.sv ====
//==========================================================================
// Arcade front end top level
//   Clock enables, keyboard decoder, per-player mappers,
//   button merger and sigma-delta audio
//==========================================================================

`timescale 1ns/1ps

`include "arcade_io_config.svh"

module arcade_io_top import arcade_io_pkg::*; (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  key_code_t                     key_data,
	input  logic                          key_valid,
	input  logic [`NUM_PLAYERS*JOY_W-1:0] joy_flat,
	input  logic                          rotate,
	input  audio_t                        audio,
	output logic                          key_ready,
	output buttons_t                      button_n,
	output logic                          audio_out,
	output logic                          ce_12,
	output logic                          ce_6p,
	output logic                          ce_6n,
	output logic                          ce_1p79
);

	joy_t                          kbd_joy;
	sys_keys_t                     sys_keys;
	logic [`NUM_PLAYERS*JOY_W-1:0] ctl_flat;

	clock_enable_gen u_clock_enable_gen (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_1p79 (ce_1p79)
	);

	key_event_decoder u_key_event_decoder (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.key_data  (key_data),
		.key_valid (key_valid),
		.key_ready (key_ready),
		.kbd_joy   (kbd_joy),
		.sys_keys  (sys_keys)
	);

	// =====================================================================
	// One mapper per joystick sharing the keyboard
	// =====================================================================
	for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : g_player
		player_input_mapper u_player_input_mapper (
			.clk_sys (clk_sys),
			.rst     (rst),
			.joy     (joy_flat[i*JOY_W +: JOY_W]),
			.kbd_joy (kbd_joy),
			.rotate  (rotate),
			.ctl     (ctl_flat[i*JOY_W +: JOY_W])
		);
	end

	control_merger u_control_merger (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ctl_flat (ctl_flat),
		.sys_keys (sys_keys),
		.button_n (button_n)
	);

	audio_dac u_audio_dac (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.audio     (audio),
		.audio_out (audio_out)
	);

endmodule

// ==== audio_dac.sv ====
//==========================================================================
// First-order sigma-delta DAC
//   Sample added to a running accumulator each cycle
//   Carry out of the top bit is the one-bit stream
//==========================================================================

`timescale 1ns/1ps

`include "arcade_io_config.svh"

module audio_dac import arcade_io_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,
	input  audio_t audio,
	output logic   audio_out
);

	logic [`AUDIO_W-1:0] acc;
	logic [`AUDIO_W:0]   sum;

	assign sum = {1'b0, acc} + {1'b0, audio};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[`AUDIO_W-1:0];
			audio_out <= sum[`AUDIO_W];
		end
	end

endmodule

// ==== clock_enable_gen.sv ====
//==========================================================================
// Clock enable generator for the game core
//   ce_12 on every second clk_sys cycle
//   ce_6p / ce_6n on alternate ce_12 pulses
//   ce_1p79 once per CE_SLOW_DIV cycles
//==========================================================================

`timescale 1ns/1ps

`include "arcade_io_config.svh"

module clock_enable_gen (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam int SLOW_W = $clog2(`CE_SLOW_DIV);

	logic [1:0]        phase;
	logic [SLOW_W-1:0] slow_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase    <= 2'd0;
			slow_cnt <= '0;
			ce_12    <= 1'b0;
			ce_6p    <= 1'b0;
			ce_6n    <= 1'b0;
			ce_1p79  <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce_12 <= phase[0];
			ce_6p <= phase[0] & ~phase[1];   // First half of the 6 MHz period
			ce_6n <= phase[0] &  phase[1];   // Second half

			// Slow enable from a reloading down counter
			ce_1p79 <= 1'b0;
			if (slow_cnt == '0) begin
				slow_cnt <= SLOW_W'(`CE_SLOW_DIV - 1);
				ce_1p79  <= 1'b1;
			end else begin
				slow_cnt <= slow_cnt - 1'b1;
			end
		end
	end

endmodule

// ==== control_merger.sv ====
//==========================================================================
// Button word for the game core
//   OR of all player channels plus coin and start keys
//   Reordered to the core's input order and inverted
//==========================================================================

`timescale 1ns/1ps

`include "arcade_io_config.svh"

module control_merger import arcade_io_pkg::*; (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic [`NUM_PLAYERS*JOY_W-1:0] ctl_flat,
	input  sys_keys_t                     sys_keys,
	output buttons_t                      button_n
);

	joy_t     any_ctl;
	buttons_t word;

	always_comb begin
		any_ctl = '0;
		for (int p = 0; p < `NUM_PLAYERS; p++) begin
			any_ctl = any_ctl | ctl_flat[p*JOY_W +: JOY_W];
		end
	end

	// Fire2 goes nowhere as this core has no bomb input
	assign word = {
		sys_keys[SYS_START2],
		any_ctl[JOY_FIRE1],
		sys_keys[SYS_COIN],
		sys_keys[SYS_START1],
		any_ctl[JOY_RIGHT],
		any_ctl[JOY_LEFT],
		any_ctl[JOY_DOWN],
		any_ctl[JOY_UP]
	};

	always_ff @(posedge clk_sys) begin
		if (rst)
			button_n <= '1;   // Nothing pressed
		else
			button_n <= ~word;
	end

endmodule

// ==== key_event_decoder.sv ====
//==========================================================================
// PS/2 scan-code decoder
//   Byte input with valid/ready that is always ready outside reset
//   Tracks the F0 break and E0 extended prefixes
//   Holds the pressed state of every mapped key
//==========================================================================

`timescale 1ns/1ps

module key_event_decoder import arcade_io_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst,
	input  key_code_t key_data,
	input  logic      key_valid,
	output logic      key_ready,
	output joy_t      kbd_joy,
	output sys_keys_t sys_keys
);

	localparam key_code_t CODE_EXT   = 8'hE0;
	localparam key_code_t CODE_BREAK = 8'hF0;

	kbd_state_t state;
	logic       take;
	logic       pressed;

	assign take    = key_valid & key_ready;
	assign pressed = (state != KBD_BREAK);   // Code after F0 is a release

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			key_ready <= 1'b0;
			state     <= KBD_IDLE;
			kbd_joy   <= '0;
			sys_keys  <= '0;
		end else begin
			key_ready <= 1'b1;

			if (take) begin
				case (key_data)
					CODE_EXT:   state <= KBD_EXT;
					CODE_BREAK: state <= KBD_BREAK;   // Also after E0
					default: begin
						state <= KBD_IDLE;

						// Key map where other codes are dropped
						case (key_data)
							8'h75: kbd_joy[JOY_UP]      <= pressed;
							8'h72: kbd_joy[JOY_DOWN]    <= pressed;
							8'h6B: kbd_joy[JOY_LEFT]    <= pressed;
							8'h74: kbd_joy[JOY_RIGHT]   <= pressed;
							8'h29: kbd_joy[JOY_FIRE1]   <= pressed;   // Space
							8'h11: kbd_joy[JOY_FIRE2]   <= pressed;   // Alt
							8'h76: sys_keys[SYS_COIN]   <= pressed;   // Escape
							8'h05: sys_keys[SYS_START1] <= pressed;   // F1
							8'h06: sys_keys[SYS_START2] <= pressed;   // F2
							default: ;
						endcase
					end
				endcase
			end
		end
	end

endmodule

// ==== player_input_mapper.sv ====
//==========================================================================
// One player's control channel
//   Joystick ORed with the keyboard directions and fire buttons
//   Optional quarter turn of the directions for a rotated monitor
//==========================================================================

`timescale 1ns/1ps

module player_input_mapper import arcade_io_pkg::*; (
	input  logic clk_sys,
	input  logic rst,
	input  joy_t joy,
	input  joy_t kbd_joy,
	input  logic rotate,
	output joy_t ctl
);

	joy_t merged;
	joy_t turned;

	always_comb begin
		merged = joy | kbd_joy;

		turned = '0;   // Unused top bits stay low
		turned[JOY_FIRE1] = merged[JOY_FIRE1];
		turned[JOY_FIRE2] = merged[JOY_FIRE2];

		if (rotate) begin
			turned[JOY_UP]    = merged[JOY_LEFT];
			turned[JOY_DOWN]  = merged[JOY_RIGHT];
			turned[JOY_LEFT]  = merged[JOY_DOWN];
			turned[JOY_RIGHT] = merged[JOY_UP];
		end else begin
			turned[JOY_UP]    = merged[JOY_UP];
			turned[JOY_DOWN]  = merged[JOY_DOWN];
			turned[JOY_LEFT]  = merged[JOY_LEFT];
			turned[JOY_RIGHT] = merged[JOY_RIGHT];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			ctl <= '0;
		else
			ctl <= turned;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module arcade_io_tb \
	-f arcade_io.f -o arcade_io_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/arcade_io_sim > sim.log 2>&1
grep -qx "All tests passed" sim.log && echo "Simulation log shows a pass" \
	|| { cat sim.log; exit 1; }
